// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rn_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^>>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  issue_valid,
    input  wire rn_pkg::alu_op_e issue_op,
    input  wire rn_pkg::data_t   issue_a,
    input  wire rn_pkg::data_t   issue_b,
    input  wire rn_pkg::data_t   issue_imm,
    input  wire rn_pkg::nick_t   issue_nick,
    output logic                 cdb_valid,
    output rn_pkg::nick_t        cdb_nick,
    output rn_pkg::data_t        cdb_data
);

    rn_pkg::data_t result;

    always_comb begin
        case (issue_op)
            rn_pkg::OP_ADD:  result = issue_a + issue_b;
            rn_pkg::OP_SUB:  result = issue_a - issue_b;
            rn_pkg::OP_AND:  result = issue_a & issue_b;
            rn_pkg::OP_OR:   result = issue_a | issue_b;
            rn_pkg::OP_XOR:  result = issue_a ^ issue_b;
            rn_pkg::OP_SLT:  result = {31'b0, $signed(issue_a) < $signed(issue_b)};
            rn_pkg::OP_ADDI: result = issue_a + issue_imm;
            default:         result = issue_imm;   // LUI
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_nick <= issue_nick;
        cdb_data <= result;
    end

endmodule

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire              clk,
    input  wire              rst,
    input  wire              instr_valid,
    input  wire rn_pkg::inst_t instr,
    output logic             dec_valid,
    output rn_pkg::alu_op_e  dec_op,
    output rn_pkg::regnm_t   dec_rd,
    output rn_pkg::regnm_t   dec_rs1,
    output rn_pkg::regnm_t   dec_rs2,
    output rn_pkg::data_t    dec_imm
);

    logic            ok_next;
    rn_pkg::alu_op_e op_next;
    rn_pkg::regnm_t  rs1_next;
    rn_pkg::regnm_t  rs2_next;
    rn_pkg::data_t   imm_next;

    always_comb begin
        ok_next  = 1'b0;
        op_next  = rn_pkg::OP_ADD;
        rs1_next = instr[19:15];
        rs2_next = instr[24:20];
        imm_next = {{20{instr[31]}}, instr[31:20]};   // I-type, sign extended
        case (instr[6:0])
            rn_pkg::OPC_REG: begin
                ok_next = 1'b1;
                case ({instr[31:25], instr[14:12]})   // funct7, funct3
                    10'b0000000_000: op_next = rn_pkg::OP_ADD;
                    10'b0100000_000: op_next = rn_pkg::OP_SUB;
                    10'b0000000_111: op_next = rn_pkg::OP_AND;
                    10'b0000000_110: op_next = rn_pkg::OP_OR;
                    10'b0000000_100: op_next = rn_pkg::OP_XOR;
                    10'b0000000_010: op_next = rn_pkg::OP_SLT;
                    default:         ok_next = 1'b0;
                endcase
            end
            rn_pkg::OPC_IMM: begin
                ok_next  = (instr[14:12] == 3'b000);  // ADDI only
                op_next  = rn_pkg::OP_ADDI;
                rs2_next = '0;
            end
            rn_pkg::OPC_LUI: begin
                ok_next  = 1'b1;
                op_next  = rn_pkg::OP_LUI;
                rs1_next = '0;
                rs2_next = '0;
                imm_next = {instr[31:12], 12'b0};
            end
            default: ok_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid && ok_next;
        end
    end

    always_ff @(posedge clk) begin
        dec_op  <= op_next;
        dec_rd  <= instr[11:7];
        dec_rs1 <= rs1_next;
        dec_rs2 <= rs2_next;
        dec_imm <= imm_next;
    end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                 clk,
    input  wire                 rst,
    // Source reads
    input  wire rn_pkg::regnm_t rs1_regnm,
    input  wire rn_pkg::regnm_t rs2_regnm,
    output rn_pkg::data_t       rs1_data,
    output rn_pkg::data_t       rs2_data,
    output rn_pkg::nick_t       rs1_nick,
    output rn_pkg::nick_t       rs2_nick,
    // Rename at dispatch
    input  wire                 rename_en,
    input  wire rn_pkg::regnm_t rename_regnm,
    input  wire rn_pkg::nick_t  rename_nick,
    // Retire from the reorder buffer
    input  wire                 commit_en,
    input  wire rn_pkg::regnm_t commit_regnm,
    input  wire rn_pkg::nick_t  commit_nick,
    input  wire rn_pkg::data_t  commit_data
);

    rn_pkg::data_t reg_dt   [rn_pkg::REG_NUM];
    rn_pkg::nick_t reg_nick [rn_pkg::REG_NUM];

    logic commit_hit;

    // Only the newest writer of a register may land its value
    assign commit_hit = commit_en && (commit_regnm != '0)
                        && (reg_nick[commit_regnm] == commit_nick);

    // x0 is never written, so it reads zero with tag 0
    assign rs1_data = reg_dt[rs1_regnm];
    assign rs2_data = reg_dt[rs2_regnm];
    assign rs1_nick = reg_nick[rs1_regnm];
    assign rs2_nick = reg_nick[rs2_regnm];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rn_pkg::REG_NUM; i++) begin
                reg_dt[i]   <= '0;
                reg_nick[i] <= '0;
            end
        end else begin
            if (commit_hit) begin
                reg_dt[commit_regnm]   <= commit_data;
                reg_nick[commit_regnm] <= '0;
            end
            // Later assignment, so rename beats commit on the same register
            if (rename_en && rename_regnm != '0) begin
                reg_nick[rename_regnm] <= rename_nick;
            end
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire                 clk,
    input  wire                 rst,
    // Allocation at dispatch
    input  wire                 alloc_en,
    input  wire rn_pkg::regnm_t alloc_rd,
    output rn_pkg::nick_t       alloc_nick,
    // Operand lookups
    input  wire rn_pkg::nick_t  look1_nick,
    input  wire rn_pkg::nick_t  look2_nick,
    output logic                look1_done,
    output logic                look2_done,
    output rn_pkg::data_t       look1_data,
    output rn_pkg::data_t       look2_data,
    // Result bus snoop
    input  wire                 cdb_valid,
    input  wire rn_pkg::nick_t  cdb_nick,
    input  wire rn_pkg::data_t  cdb_data,
    // Retire
    output logic                commit_valid,
    output rn_pkg::regnm_t      commit_rd,
    output rn_pkg::nick_t       commit_nick,
    output rn_pkg::data_t       commit_data,
    output logic [2:0]          rob_count
);

    logic           done  [1:rn_pkg::ROB_DEPTH];
    rn_pkg::regnm_t rd    [1:rn_pkg::ROB_DEPTH];
    rn_pkg::data_t  value [1:rn_pkg::ROB_DEPTH];   // Held until slot is reused

    rn_pkg::nick_t head;
    rn_pkg::nick_t tail;
    logic [2:0]    count;

    function automatic rn_pkg::nick_t next_slot(rn_pkg::nick_t p);
        return (p == rn_pkg::nick_t'(rn_pkg::ROB_DEPTH)) ? rn_pkg::nick_t'(1)
                                                          : p + rn_pkg::nick_t'(1);
    endfunction

    assign alloc_nick = tail;
    assign rob_count  = count;

    // Tag 0 is a register file value, never a slot
    assign look1_done = (look1_nick != '0) && done[look1_nick];
    assign look2_done = (look2_nick != '0) && done[look2_nick];
    assign look1_data = value[look1_nick];
    assign look2_data = value[look2_nick];

    assign commit_valid = (count != '0) && done[head];
    assign commit_rd    = rd[head];
    assign commit_nick  = head;
    assign commit_data  = value[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= rn_pkg::nick_t'(1);
            tail  <= rn_pkg::nick_t'(1);
            count <= '0;
            for (int i = 1; i <= rn_pkg::ROB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (cdb_valid) begin
                done[cdb_nick]  <= 1'b1;
                value[cdb_nick] <= cdb_data;
            end
            if (alloc_en) begin
                done[tail] <= 1'b0;
                rd[tail]   <= alloc_rd;
                tail       <= next_slot(tail);
            end
            if (commit_valid) begin
                head <= next_slot(head);
            end
            count <= count + {2'b0, alloc_en} - {2'b0, commit_valid};
        end
    end

endmodule

`default_nettype wire

// File: rn_core.sv
`timescale 1ns/1ps
`default_nettype none

module rn_core (
    input  wire                clk,
    input  wire                rst,
    input  wire                instr_valid,
    input  wire rn_pkg::inst_t instr,
    output logic               commit_valid,
    output rn_pkg::regnm_t     commit_rd,
    output rn_pkg::nick_t      commit_nick,
    output rn_pkg::data_t      commit_data
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic            dec_valid;
    rn_pkg::alu_op_e dec_op;
    rn_pkg::regnm_t  dec_rd;
    rn_pkg::regnm_t  dec_rs1;
    rn_pkg::regnm_t  dec_rs2;
    rn_pkg::data_t   dec_imm;

    rn_pkg::data_t   rs1_data;
    rn_pkg::data_t   rs2_data;
    rn_pkg::nick_t   rs1_nick;
    rn_pkg::nick_t   rs2_nick;

    rn_pkg::nick_t   alloc_nick;
    logic            look1_done;
    logic            look2_done;
    rn_pkg::data_t   look1_data;
    rn_pkg::data_t   look2_data;

    logic            src1_ready;
    logic            src2_ready;
    rn_pkg::data_t   src1_data;
    rn_pkg::data_t   src2_data;

    logic            issue_valid;
    rn_pkg::alu_op_e issue_op;
    rn_pkg::data_t   issue_a;
    rn_pkg::data_t   issue_b;
    rn_pkg::data_t   issue_imm;
    rn_pkg::nick_t   issue_nick;

    logic            cdb_valid;
    rn_pkg::nick_t   cdb_nick;
    rn_pkg::data_t   cdb_data;

    logic [2:0]      rs_count;
    logic [2:0]      rob_count;

    logic            cdb_hit1;
    logic            cdb_hit2;

    inst_decoder u_dec (
        .clk, .rst, .instr_valid, .instr,
        .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm
    );

    regfile u_rf (
        .clk, .rst,
        .rs1_regnm    (dec_rs1),
        .rs2_regnm    (dec_rs2),
        .rs1_data, .rs2_data, .rs1_nick, .rs2_nick,
        .rename_en    (dec_valid),
        .rename_regnm (dec_rd),
        .rename_nick  (alloc_nick),
        .commit_en    (commit_valid),
        .commit_regnm (commit_rd),
        .commit_nick, .commit_data
    );

    // Operand resolution at dispatch
    assign cdb_hit1   = cdb_valid && (cdb_nick == rs1_nick);
    assign cdb_hit2   = cdb_valid && (cdb_nick == rs2_nick);
    assign src1_ready = (rs1_nick == '0) || look1_done || cdb_hit1;
    assign src2_ready = (rs2_nick == '0) || look2_done || cdb_hit2;
    assign src1_data  = (rs1_nick == '0) ? rs1_data : look1_done ? look1_data : cdb_data;
    assign src2_data  = (rs2_nick == '0) ? rs2_data : look2_done ? look2_data : cdb_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute and result stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rsv_station u_rs (
        .clk, .rst,
        .disp_en   (dec_valid),
        .disp_op   (dec_op),
        .disp_imm  (dec_imm),
        .disp_nick (alloc_nick),
        .src1_nick (rs1_nick),
        .src2_nick (rs2_nick),
        .src1_ready, .src2_ready, .src1_data, .src2_data,
        .cdb_valid, .cdb_nick, .cdb_data,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_imm, .issue_nick,
        .rs_count
    );

    alu_unit u_alu (
        .clk, .rst,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_imm, .issue_nick,
        .cdb_valid, .cdb_nick, .cdb_data
    );

    reorder_buffer u_rob (
        .clk, .rst,
        .alloc_en   (dec_valid),
        .alloc_rd   (dec_rd),
        .alloc_nick,
        .look1_nick (rs1_nick),
        .look2_nick (rs2_nick),
        .look1_done, .look2_done, .look1_data, .look2_data,
        .cdb_valid, .cdb_nick, .cdb_data,
        .commit_valid, .commit_rd, .commit_nick, .commit_data,
        .rob_count
    );

endmodule

`default_nettype wire

// File: rn_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rn_core_props (
    input wire       clk,
    input wire       rst,
    input wire       instr_valid,
    input wire       dec_valid,
    input wire       commit_valid,
    input wire [2:0] rs_count,
    input wire [2:0] rob_count
);

    // Dispatch needs a free slot in both buffers
    a_rs_room: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> rs_count < 3'(rn_pkg::RS_DEPTH))
        else $error("dispatch into a full reservation station");

    a_rob_room: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> (rob_count < 3'(rn_pkg::ROB_DEPTH)) || commit_valid)
        else $error("dispatch into a full reorder buffer");

    a_strobe_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(instr_valid))
        else $error("instruction strobe is unknown");

endmodule

bind rn_core rn_core_props u_props (
    .clk, .rst, .instr_valid, .dec_valid, .commit_valid, .rs_count, .rob_count
);

`default_nettype wire

// File: rn_pkg.sv
`default_nettype none

package rn_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int REG_NUM   = 32;
    localparam int RS_DEPTH  = 4;
    localparam int ROB_DEPTH = 7;   // Slots 1..7, tag 0 means in regfile

    // RV32I major opcodes that survive decode
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] data_t;
    typedef logic [4:0]  regnm_t;
    typedef logic [2:0]  nick_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  rs_idx_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI
    } alu_op_e;

endpackage

`default_nettype wire

// File: rsv_station.sv
`timescale 1ns/1ps
`default_nettype none

module rsv_station (
    input  wire                  clk,
    input  wire                  rst,
    // Dispatch
    input  wire                  disp_en,
    input  wire rn_pkg::alu_op_e disp_op,
    input  wire rn_pkg::data_t   disp_imm,
    input  wire rn_pkg::nick_t   disp_nick,
    input  wire rn_pkg::nick_t   src1_nick,
    input  wire rn_pkg::nick_t   src2_nick,
    input  wire                  src1_ready,
    input  wire                  src2_ready,
    input  wire rn_pkg::data_t   src1_data,
    input  wire rn_pkg::data_t   src2_data,
    // Result bus snoop
    input  wire                  cdb_valid,
    input  wire rn_pkg::nick_t   cdb_nick,
    input  wire rn_pkg::data_t   cdb_data,
    // Issue
    output logic                 issue_valid,
    output rn_pkg::alu_op_e      issue_op,
    output rn_pkg::data_t        issue_a,
    output rn_pkg::data_t        issue_b,
    output rn_pkg::data_t        issue_imm,
    output rn_pkg::nick_t        issue_nick,
    output logic [2:0]           rs_count
);

    logic [rn_pkg::RS_DEPTH-1:0] busy;
    rn_pkg::alu_op_e op    [rn_pkg::RS_DEPTH];
    rn_pkg::data_t   imm   [rn_pkg::RS_DEPTH];
    rn_pkg::nick_t   dnick [rn_pkg::RS_DEPTH];   // Destination tag
    rn_pkg::nick_t   q1    [rn_pkg::RS_DEPTH];
    rn_pkg::nick_t   q2    [rn_pkg::RS_DEPTH];
    logic            r1    [rn_pkg::RS_DEPTH];
    logic            r2    [rn_pkg::RS_DEPTH];
    rn_pkg::data_t   v1    [rn_pkg::RS_DEPTH];
    rn_pkg::data_t   v2    [rn_pkg::RS_DEPTH];
    rn_pkg::rs_idx_t age   [rn_pkg::RS_DEPTH];   // Count of younger entries

    rn_pkg::rs_idx_t sel;
    rn_pkg::rs_idx_t free_slot;
    logic            free_found;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Oldest-ready pick and free slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        free_slot   = '0;
        free_found  = 1'b0;
        rs_count    = '0;
        for (int i = 0; i < rn_pkg::RS_DEPTH; i++) begin
            if (busy[i]) begin
                rs_count = rs_count + 3'd1;
            end
            if (busy[i] && r1[i] && r2[i] && (!issue_valid || age[i] > age[sel])) begin
                issue_valid = 1'b1;
                sel         = rn_pkg::rs_idx_t'(i);
            end
            if (!busy[i] && !free_found) begin
                free_found = 1'b1;
                free_slot  = rn_pkg::rs_idx_t'(i);
            end
        end
    end

    assign issue_op   = op[sel];
    assign issue_a    = v1[sel];
    assign issue_b    = v2[sel];
    assign issue_imm  = imm[sel];
    assign issue_nick = dnick[sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < rn_pkg::RS_DEPTH; i++) begin
                if (busy[i]) begin
                    if (!r1[i] && cdb_valid && q1[i] == cdb_nick) begin
                        r1[i] <= 1'b1;
                        v1[i] <= cdb_data;
                    end
                    if (!r2[i] && cdb_valid && q2[i] == cdb_nick) begin
                        r2[i] <= 1'b1;
                        v2[i] <= cdb_data;
                    end
                    // Older entries close the gap left by the issued one
                    age[i] <= age[i] + {1'b0, disp_en}
                              - {1'b0, issue_valid && (age[i] > age[sel])};
                end
            end
            if (issue_valid) begin
                busy[sel] <= 1'b0;
            end
            if (disp_en) begin
                busy[free_slot]  <= 1'b1;
                op[free_slot]    <= disp_op;
                imm[free_slot]   <= disp_imm;
                dnick[free_slot] <= disp_nick;
                q1[free_slot]    <= src1_nick;
                q2[free_slot]    <= src2_nick;
                r1[free_slot]    <= src1_ready;
                r2[free_slot]    <= src2_ready;
                v1[free_slot]    <= src1_data;
                v2[free_slot]    <= src2_data;
                age[free_slot]   <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
rn_pkg.sv
inst_decoder.sv
regfile.sv
rsv_station.sv
alu_unit.sv
reorder_buffer.sv
rn_core.sv
rn_core_props.sv
tb_rn_core.sv

// File: tb_rn_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rn_core;

    localparam int MAX_INSTR     = 100;
    localparam int CYC_PER_INSTR = 20;   // Slowest dependent instruction plus drain
    localparam int MAX_CYCLES    = MAX_INSTR * CYC_PER_INSTR;
    localparam int IN_FLIGHT     = 4;    // Sent but not yet committed

    logic           clk;
    logic           rst;
    logic           instr_valid;
    rn_pkg::inst_t  instr;
    logic           commit_valid;
    rn_pkg::regnm_t commit_rd;
    rn_pkg::nick_t  commit_nick;
    rn_pkg::data_t  commit_data;

    // Reference model state
    rn_pkg::data_t  ref_regs [rn_pkg::REG_NUM];
    rn_pkg::regnm_t exp_rd   [$];
    rn_pkg::data_t  exp_val  [$];
    rn_pkg::nick_t  exp_nick [$];
    rn_pkg::regnm_t want_rd;
    rn_pkg::data_t  want_val;
    rn_pkg::nick_t  want_nick;
    int             sent_count;
    int             commit_count = 0;
    int             cycle_count  = 0;
    logic [31:0]    lfsr;

    rn_core dut (
        .clk, .rst, .instr_valid, .instr,
        .commit_valid, .commit_rd, .commit_nick, .commit_data
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input rn_pkg::data_t got,
                              input rn_pkg::data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_regnm(input string name, input rn_pkg::regnm_t got,
                               input rn_pkg::regnm_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_nick(input string name, input rn_pkg::nick_t got,
                              input rn_pkg::nick_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic rn_pkg::data_t rand_bits(input int n);
        rn_pkg::data_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i] = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction drivers with model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_word(input rn_pkg::inst_t w);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic send_expected(input rn_pkg::inst_t w, input rn_pkg::regnm_t rd,
                                 input rn_pkg::data_t value);
        while (sent_count - commit_count >= IN_FLIGHT) begin
            @(negedge clk);
        end
        exp_rd.push_back(rd);
        exp_val.push_back(value);
        // Slots 1..7 handed out in turn from reset, one per supported instruction
        exp_nick.push_back(rn_pkg::nick_t'(sent_count % rn_pkg::ROB_DEPTH + 1));
        if (rd != '0) begin
            ref_regs[rd] = value;   // x0 stays zero
        end
        sent_count++;
        drive_word(w);
    endtask

    task automatic send_rr(input rn_pkg::alu_op_e op, input rn_pkg::regnm_t rd,
                           input rn_pkg::regnm_t rs1, input rn_pkg::regnm_t rs2);
        logic [6:0]    f7;
        logic [2:0]    f3;
        rn_pkg::data_t a;
        rn_pkg::data_t b;
        rn_pkg::data_t r;
        a  = ref_regs[rs1];
        b  = ref_regs[rs2];
        f7 = 7'h00;
        case (op)
            rn_pkg::OP_SUB: begin
                f7 = 7'h20;
                f3 = 3'b000;
                r  = a - b;
            end
            rn_pkg::OP_AND: begin
                f3 = 3'b111;
                r  = a & b;
            end
            rn_pkg::OP_OR: begin
                f3 = 3'b110;
                r  = a | b;
            end
            rn_pkg::OP_XOR: begin
                f3 = 3'b100;
                r  = a ^ b;
            end
            rn_pkg::OP_SLT: begin
                f3 = 3'b010;
                // Differing signs decide by a's sign, else plain magnitude
                if (a[31] != b[31]) begin
                    r = {31'b0, a[31]};
                end else begin
                    r = {31'b0, a < b};
                end
            end
            default: begin
                f3 = 3'b000;
                r  = a + b;
            end
        endcase
        send_expected({f7, rs2, rs1, f3, rd, 7'b0110011}, rd, r);
    endtask

    task automatic send_addi(input rn_pkg::regnm_t rd, input rn_pkg::regnm_t rs1,
                             input logic [11:0] imm);
        rn_pkg::data_t r;
        r = ref_regs[rs1] + {{20{imm[11]}}, imm};
        send_expected({imm, rs1, 3'b000, rd, 7'b0010011}, rd, r);
    endtask

    task automatic send_lui(input rn_pkg::regnm_t rd, input logic [19:0] imm);
        send_expected({imm, rd, 7'b0110111}, rd, {imm, 12'h000});
    endtask

    // LUI then ADDI, upper part rounded for the sign of the low part
    task automatic load_const(input rn_pkg::regnm_t rd, input rn_pkg::data_t v);
        logic [19:0] hi;
        hi = v[31:12] + {19'b0, v[11]};
        send_lui(rd, hi);
        send_addi(rd, rd, v[11:0]);
    endtask

    task automatic wait_drain;
        while (commit_count != sent_count) begin
            @(negedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_constants;
        send_lui(5'd1, 20'h12345);
        send_addi(5'd1, 5'd1, 12'h678);
        send_addi(5'd2, 5'd0, 12'hFFF);   // -1
        send_lui(5'd3, 20'h80000);
        send_addi(5'd4, 5'd3, 12'h7FF);
        load_const(5'd5, 32'hDEAD_BEEF);
        wait_drain;
    endtask

    task automatic test_reg_ops;
        load_const(5'd10, rand_bits(32));
        load_const(5'd11, rand_bits(32));
        load_const(5'd12, rand_bits(31) | 32'h8000_0000);   // Negative
        load_const(5'd13, rand_bits(31));
        send_rr(rn_pkg::OP_ADD, 5'd14, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_SUB, 5'd15, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_AND, 5'd16, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_OR,  5'd17, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_XOR, 5'd18, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_SLT, 5'd19, 5'd10, 5'd11);
        send_rr(rn_pkg::OP_SLT, 5'd20, 5'd12, 5'd13);
        send_rr(rn_pkg::OP_SLT, 5'd21, 5'd13, 5'd12);
        wait_drain;
    endtask

    task automatic test_dep_chain;
        send_addi(5'd1, 5'd0, 12'd5);
        send_rr(rn_pkg::OP_ADD, 5'd2, 5'd1, 5'd1);
        send_rr(rn_pkg::OP_SUB, 5'd3, 5'd2, 5'd1);
        send_rr(rn_pkg::OP_XOR, 5'd4, 5'd3, 5'd2);
        send_addi(5'd5, 5'd4, 12'hFFD);
        send_lui(5'd6, 20'h0BEEF);        // Independent tail
        send_addi(5'd7, 5'd0, 12'd9);
        wait_drain;
    endtask

    task automatic test_rename_overlap;
        send_addi(5'd7, 5'd0, 12'd111);
        send_addi(5'd7, 5'd0, 12'd222);
        send_rr(rn_pkg::OP_ADD, 5'd8, 5'd7, 5'd0);   // Must see 222
        wait_drain;
        send_addi(5'd9, 5'd7, 12'd1);
        wait_drain;
    endtask

    task automatic test_x0_and_unsupported;
        send_addi(5'd0, 5'd0, 12'd55);
        send_lui(5'd0, 20'hABCDE);
        drive_word({12'd4, 5'd1, 3'b010, 5'd9, 7'b0000011});          // LW
        drive_word({7'h20, 5'd2, 5'd1, 3'b111, 5'd9, 7'b0110011});    // Bad funct7
        drive_word({12'd1, 5'd1, 3'b001, 5'd9, 7'b0010011});          // SLLI
        drive_word({7'h00, 5'd0, 5'd0, 3'b000, 5'd9, 7'b1100011});    // BEQ
        send_rr(rn_pkg::OP_ADD, 5'd5, 5'd0, 5'd0);
        wait_drain;
        repeat (8) @(negedge clk);   // Room for a stray commit
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit monitor and cycle limit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_rd.size() == 0) begin
                report_failure("Commit seen with no instruction outstanding");
            end else begin
                want_rd   = exp_rd.pop_front();
                want_val  = exp_val.pop_front();
                want_nick = exp_nick.pop_front();
                check_regnm("commit_rd", commit_rd, want_rd);
                check_nick("commit_nick", commit_nick, want_nick);
                check_data("commit_data", commit_data, want_val);
                commit_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout: run exceeded %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'heafb_0bfd;
        sent_count  = 0;
        for (int i = 0; i < rn_pkg::REG_NUM; i++) begin
            ref_regs[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        test_constants;
        test_reg_ops;
        test_dep_chain;
        test_rename_overlap;
        test_x0_and_unsupported;

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
